//--- hdl/cond_pkg.sv
/*
  flag word and condition codes of the execution slice,
  used by the condition logic and by the result merge
*/
`default_nettype none

package cond_pkg;

  typedef struct packed {
    logic z;  // zero
    logic s;  // sign
    logic c;  // carry out, or borrow on sub
    logic o;  // signed overflow
  } flags_t;

  typedef enum logic [3:0] {
    cond_eq = 4'd0,
    cond_ne = 4'd1,
    cond_lt = 4'd2,
    cond_ge = 4'd3,
    cond_cs = 4'd4,
    cond_be = 4'd5,
    cond_cc = 4'd6,
    cond_ab = 4'd7,
    cond_mi = 4'd8,
    cond_pl = 4'd9,
    cond_vs = 4'd10,
    cond_al = 4'd11,
    cond_vc = 4'd12,
    cond_gt = 4'd13,
    cond_le = 4'd14,
    cond_nv = 4'd15
  } cond_e;

endpackage

`default_nettype wire

//--- hdl/exec_pkg.sv
/*
  operation word encodings and the issue and result records
  of the execution slice
*/
`default_nettype none

package exec_pkg;

  localparam int DATA_W  = 64;
  localparam int LATENCY = 2;  // issue to result, in cycles

  typedef enum logic [1:0] {
    class_arith = 2'd0,
    class_logic = 2'd1,
    class_shift = 2'd2
  } op_class_e;

  // add and sub under class_arith, the rest under class_logic
  typedef enum logic [2:0] {
    func_add = 3'd0,
    func_sub = 3'd1,
    func_and = 3'd2,
    func_or  = 3'd3,
    func_xor = 3'd4
  } arith_func_e;

  typedef enum logic {
    dir_left  = 1'b0,
    dir_right = 1'b1
  } shift_dir_e;

  // op_class at [15:14] and cond at [10:7] in both forms
  typedef struct packed {
    op_class_e       op_class;
    arith_func_e     func;
    cond_pkg::cond_e cond;
    logic [6:0]      spare;
  } arith_form_t;

  typedef struct packed {
    op_class_e       op_class;
    shift_dir_e      dir;
    logic            arith;    // sign fill on right shift
    logic            use_imm;
    cond_pkg::cond_e cond;
    logic [5:0]      imm_amt;
    logic            spare;
  } shift_form_t;

  typedef union packed {
    arith_form_t arith;
    shift_form_t shift;
  } op_word_u;

  typedef struct packed {
    logic              valid;
    op_word_u          op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    cond_pkg::flags_t  flags_in;
  } issue_t;

  typedef struct packed {
    logic              valid;
    logic              wr_en;
    logic [DATA_W-1:0] data;
    cond_pkg::flags_t  flags;
  } result_t;

endpackage

`default_nettype wire

//--- hdl/int_alu.sv
/*
  two-stage integer datapath. add and sub run in two halves with the low
  carry handed to the high half a cycle later; logic and shifts follow the
  same timing. data and flags are registered two cycles after issue
*/
`timescale 1ns/1ps
`default_nettype none

module int_alu #(
  parameter int SPLIT_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  exec_pkg::issue_t  issue,
  output exec_pkg::result_t alu_out
);

  localparam int DW   = exec_pkg::DATA_W;
  localparam int HI_W = DW - SPLIT_W;

  logic              is_sub;
  logic [DW-1:0]     b_eff;
  logic [SPLIT_W:0]  sum_lo;
  logic [DW-1:0]     lo_logic;
  logic [5:0]        amt;

  logic              valid_s1;
  exec_pkg::op_word_u op_s1;
  logic [DW-1:0]     a_s1;       // full operand, shifts need the low half too
  logic [HI_W-1:0]   b_hi_s1;
  logic [5:0]        amt_s1;
  logic [SPLIT_W-1:0] lo_s1;
  logic              carry_s1;

  logic              sub_s1;
  logic [HI_W:0]     sum_hi;
  logic [DW-1:0]     hi_logic;
  logic signed [DW-1:0] a_signed;
  logic [DW-1:0]     shift_res;
  logic [DW-1:0]     res;
  logic              res_c;
  logic              res_o;

  logic              valid_s2;
  logic [DW-1:0]     data_s2;
  cond_pkg::flags_t  flags_s2;

  function automatic logic [DW-1:0] logic_op(input exec_pkg::arith_func_e f,
                                             input logic [DW-1:0] x,
                                             input logic [DW-1:0] y);
    case (f)
      exec_pkg::func_and: logic_op = x & y;
      exec_pkg::func_or:  logic_op = x | y;
      default:            logic_op = x ^ y;
    endcase
  endfunction

  // stage 1, low half
  assign is_sub = issue.op.arith.op_class == exec_pkg::class_arith &&
                  issue.op.arith.func == exec_pkg::func_sub;
  assign b_eff    = is_sub ? ~issue.b : issue.b;  // a + ~b + 1
  assign sum_lo   = {1'b0, issue.a[SPLIT_W-1:0]} + {1'b0, b_eff[SPLIT_W-1:0]} +
                    {{SPLIT_W{1'b0}}, is_sub};
  assign lo_logic = logic_op(issue.op.arith.func, issue.a, issue.b);
  assign amt      = issue.op.shift.use_imm ? issue.op.shift.imm_amt : issue.b[5:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= issue.valid;
    end
    op_s1    <= issue.op;
    a_s1     <= issue.a;
    b_hi_s1  <= b_eff[DW-1:SPLIT_W];
    amt_s1   <= amt;
    lo_s1    <= issue.op.arith.op_class == exec_pkg::class_logic ?
                lo_logic[SPLIT_W-1:0] : sum_lo[SPLIT_W-1:0];
    carry_s1 <= sum_lo[SPLIT_W];
  end

  // stage 2, high half and shifts
  assign sub_s1 = op_s1.arith.op_class == exec_pkg::class_arith &&
                  op_s1.arith.func == exec_pkg::func_sub;
  assign sum_hi   = {1'b0, a_s1[DW-1:SPLIT_W]} + {1'b0, b_hi_s1} +
                    {{HI_W{1'b0}}, carry_s1};
  assign hi_logic = logic_op(op_s1.arith.func, {{SPLIT_W{1'b0}}, a_s1[DW-1:SPLIT_W]},
                             {{SPLIT_W{1'b0}}, b_hi_s1});
  assign a_signed = a_s1;

  always_comb begin
    if (op_s1.shift.dir == exec_pkg::dir_left) begin
      shift_res = a_s1 << amt_s1;
    end else if (op_s1.shift.arith) begin
      shift_res = a_signed >>> amt_s1;
    end else begin
      shift_res = a_s1 >> amt_s1;
    end
  end

  always_comb begin
    res_c = 1'b0;
    res_o = 1'b0;
    case (op_s1.arith.op_class)
      exec_pkg::class_logic: res = {hi_logic[HI_W-1:0], lo_s1};
      exec_pkg::class_shift: res = shift_res;
      default: begin
        res   = {sum_hi[HI_W-1:0], lo_s1};
        res_c = sum_hi[HI_W] ^ sub_s1;  // borrow is the missing carry
        res_o = (a_s1[DW-1] == b_hi_s1[HI_W-1]) && (sum_hi[HI_W-1] != a_s1[DW-1]);
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_s2 <= 1'b0;
    end else begin
      valid_s2 <= valid_s1;
    end
    data_s2  <= res;
    flags_s2 <= '{z: res == '0, s: res[DW-1], c: res_c, o: res_o};
  end

  assign alu_out = '{valid: valid_s2, wr_en: 1'b0, data: data_s2, flags: flags_s2};

endmodule

`default_nettype wire

//--- hdl/cond_eval.sv
/*
  evaluates the issue's condition code against its flags_in and
  registers the outcome, one cycle after issue
*/
`timescale 1ns/1ps
`default_nettype none

module cond_eval (
  input  logic             clk,
  input  logic             rst,
  input  exec_pkg::issue_t issue,
  output logic             cond_ok,
  output logic             cond_valid,
  output cond_pkg::flags_t flags_prev
);

  cond_pkg::flags_t f;
  logic             ok;

  assign f = issue.flags_in;

  // cond sits at the same bits in both op forms
  always_comb begin
    ok = 1'b0;
    case (issue.op.arith.cond)
      cond_pkg::cond_eq: ok = f.z;
      cond_pkg::cond_ne: ok = !f.z;
      cond_pkg::cond_lt: ok = f.s ^ f.o;
      cond_pkg::cond_ge: ok = !(f.s ^ f.o);
      cond_pkg::cond_cs: ok = f.c;
      cond_pkg::cond_be: ok = f.c | f.z;
      cond_pkg::cond_cc: ok = !f.c;
      cond_pkg::cond_ab: ok = !f.c && !f.z;
      cond_pkg::cond_mi: ok = f.s;
      cond_pkg::cond_pl: ok = !f.s;
      cond_pkg::cond_vs: ok = f.o;
      cond_pkg::cond_al: ok = 1'b1;
      cond_pkg::cond_vc: ok = !f.o;
      cond_pkg::cond_gt: ok = !(f.s ^ f.o) && !f.z;
      cond_pkg::cond_le: ok = (f.s ^ f.o) | f.z;
      cond_pkg::cond_nv: ok = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cond_valid <= 1'b0;
    end else begin
      cond_valid <= issue.valid;
    end
    cond_ok    <= ok;
    flags_prev <= issue.flags_in;  // kept when the condition fails
  end

endmodule

`default_nettype wire

//--- hdl/result_merge.sv
/*
  holds the condition outcome one more cycle so it meets the datapath
  output, then forms the write enable and picks new or old flags
*/
`timescale 1ns/1ps
`default_nettype none

module result_merge (
  input  logic              clk,
  input  logic              rst,
  input  exec_pkg::result_t alu_out,
  input  logic              cond_ok,
  input  logic              cond_valid,
  input  cond_pkg::flags_t  flags_prev,
  output exec_pkg::result_t result
);

  logic             ok_d;
  logic             valid_d;
  cond_pkg::flags_t flags_d;
  logic             take_new;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_d <= 1'b0;
    end else begin
      valid_d <= cond_valid;
    end
    ok_d    <= cond_ok;
    flags_d <= flags_prev;
  end

  // condition held for this op
  assign take_new = valid_d & ok_d;

  assign result = '{
    valid: alu_out.valid,
    wr_en: take_new,
    data:  alu_out.data,  // data goes out even when not written
    flags: take_new ? alu_out.flags : flags_d
  };

endmodule

`default_nettype wire

//--- hdl/exec_slice.sv
/*
  top of the execution slice. one issue per cycle in, one result
  strobe out two cycles later, no back-pressure
*/
`timescale 1ns/1ps
`default_nettype none

module exec_slice #(
  parameter int SPLIT_W = 32  // low half width of the adder
) (
  input  logic              clk,
  input  logic              rst,
  input  exec_pkg::issue_t  issue,
  output exec_pkg::result_t result
);

  exec_pkg::result_t alu_out;
  logic              cond_ok;
  logic              cond_valid;
  cond_pkg::flags_t  flags_prev;

  int_alu #(
    .SPLIT_W (SPLIT_W)
  ) u_int_alu (
    .clk     (clk),
    .rst     (rst),
    .issue   (issue),
    .alu_out (alu_out)
  );

  cond_eval u_cond_eval (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .cond_ok    (cond_ok),
    .cond_valid (cond_valid),
    .flags_prev (flags_prev)
  );

  result_merge u_result_merge (
    .clk        (clk),
    .rst        (rst),
    .alu_out    (alu_out),
    .cond_ok    (cond_ok),
    .cond_valid (cond_valid),
    .flags_prev (flags_prev),
    .result     (result)
  );

endmodule

`default_nettype wire

//--- verification/exec_slice_checker.sv
/*
  port timing assertions for the execution slice,
  bound into every exec_slice instance
*/
`timescale 1ns/1ps
`default_nettype none

module exec_slice_checker (
  input logic              clk,
  input logic              rst,
  input exec_pkg::issue_t  issue,
  input exec_pkg::result_t result
);

  int unsigned assert_errs = 0;

  // fixed latency from issue strobe to result strobe
  a_latency: assert property (@(posedge clk) disable iff (rst)
    result.valid == $past(issue.valid, exec_pkg::LATENCY))
    else begin
      $error("result.valid does not follow issue.valid by the fixed latency");
      assert_errs++;
    end

  a_wr_needs_valid: assert property (@(posedge clk) disable iff (rst)
    result.wr_en |-> result.valid)
    else begin
      $error("result.wr_en raised without result.valid");
      assert_errs++;
    end

  // quiet during reset and the cycle after it
  a_reset_quiet: assert property (@(posedge clk)
    rst |=> !result.valid && !result.wr_en)
    else begin
      $error("result strobe or write enable seen in or right after reset");
      assert_errs++;
    end

endmodule

bind exec_slice exec_slice_checker u_checker (
  .clk    (clk),
  .rst    (rst),
  .issue  (issue),
  .result (result)
);

`default_nettype wire

//--- verification/exec_slice_tb.sv
/*
  testbench for the execution slice. drives directed and random operations,
  predicts each result from the arithmetic and condition rules and
  compares in issue order
*/
`timescale 1ns/1ps
`default_nettype none

module exec_slice_tb;

  localparam int SPLIT_W     = 32;
  localparam int RST_CYCLES  = 16;
  localparam int GAP_SLOTS   = 60;
  localparam int ISSUE_SLOTS = 16 + 26 + 48 + 64 + 200 + GAP_SLOTS;
  localparam int CYCLE_LIMIT = RST_CYCLES + ISSUE_SLOTS + 64;

  logic              clk = 1'b0;
  logic              rst;
  exec_pkg::issue_t  issue;
  exec_pkg::result_t result;

  exec_pkg::result_t expect_q[$];
  exec_pkg::result_t exp_r;
  logic [31:0]       rng = 32'hec90;
  logic              valid_d1 = 1'b0;  // issue strobe history
  logic              valid_d2 = 1'b0;
  int                errors = 0;
  int                n_issued = 0;
  int                n_checked = 0;
  int                ops_mark = 0;
  int                err_mark = 0;

  exec_slice #(
    .SPLIT_W (SPLIT_W)
  ) UUT (
    .clk    (clk),
    .rst    (rst),
    .issue  (issue),
    .result (result)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    hi = next_rand();
    return {hi, next_rand()};
  endfunction

  function automatic exec_pkg::issue_t arith_op(input exec_pkg::op_class_e cls,
      input exec_pkg::arith_func_e fn, input cond_pkg::cond_e cc,
      input logic [63:0] a, input logic [63:0] b, input cond_pkg::flags_t fl);
    exec_pkg::issue_t t;
    t = '0;
    t.valid = 1'b1;
    t.op.arith.op_class = cls;
    t.op.arith.func = fn;
    t.op.arith.cond = cc;
    t.a = a;
    t.b = b;
    t.flags_in = fl;
    return t;
  endfunction

  function automatic exec_pkg::issue_t shift_op(input exec_pkg::shift_dir_e dir,
      input logic fill, input logic use_imm, input logic [5:0] imm,
      input cond_pkg::cond_e cc, input logic [63:0] a, input logic [63:0] b,
      input cond_pkg::flags_t fl);
    exec_pkg::issue_t t;
    t = '0;
    t.valid = 1'b1;
    t.op.shift.op_class = exec_pkg::class_shift;
    t.op.shift.dir = dir;
    t.op.shift.arith = fill;
    t.op.shift.use_imm = use_imm;
    t.op.shift.imm_amt = imm;
    t.op.shift.cond = cc;
    t.a = a;
    t.b = b;
    t.flags_in = fl;
    return t;
  endfunction

  function automatic exec_pkg::issue_t random_op();
    logic [31:0] r;
    logic [63:0] a;
    logic [63:0] b;
    r = next_rand();
    a = rand64();
    b = rand64();
    if (r[1:0] == 2'd2)
      return shift_op(exec_pkg::shift_dir_e'(r[4]), r[5], r[6], r[21:16],
                      cond_pkg::cond_e'(r[11:8]), a, b, cond_pkg::flags_t'(r[15:12]));
    if (r[1:0] == 2'd1)
      return arith_op(exec_pkg::class_logic, r[3:2] == 2'd0 ? exec_pkg::func_and :
                      r[3:2] == 2'd1 ? exec_pkg::func_or : exec_pkg::func_xor,
                      cond_pkg::cond_e'(r[11:8]), a, b, cond_pkg::flags_t'(r[15:12]));
    return arith_op(exec_pkg::class_arith, r[2] ? exec_pkg::func_sub : exec_pkg::func_add,
                    cond_pkg::cond_e'(r[11:8]), a, b, cond_pkg::flags_t'(r[15:12]));
  endfunction

  function automatic logic cond_holds(input cond_pkg::cond_e cc, input cond_pkg::flags_t f);
    logic lt;
    lt = f.s ^ f.o;  // signed less than
    case (cc)
      cond_pkg::cond_eq: return f.z;
      cond_pkg::cond_ne: return !f.z;
      cond_pkg::cond_lt: return lt;
      cond_pkg::cond_ge: return !lt;
      cond_pkg::cond_cs: return f.c;
      cond_pkg::cond_be: return f.c || f.z;
      cond_pkg::cond_cc: return !f.c;
      cond_pkg::cond_ab: return !f.c && !f.z;
      cond_pkg::cond_mi: return f.s;
      cond_pkg::cond_pl: return !f.s;
      cond_pkg::cond_vs: return f.o;
      cond_pkg::cond_al: return 1'b1;
      cond_pkg::cond_vc: return !f.o;
      cond_pkg::cond_gt: return !lt && !f.z;
      cond_pkg::cond_le: return lt || f.z;
      default:           return 1'b0;  // nv
    endcase
  endfunction

  function automatic exec_pkg::result_t expected_result(input exec_pkg::issue_t t);
    exec_pkg::result_t r;
    cond_pkg::flags_t  f;
    logic [64:0]       wide;
    logic [5:0]        amt;
    logic              holds;
    f = '0;
    r = '0;
    amt = t.op.shift.use_imm ? t.op.shift.imm_amt : t.b[5:0];
    case (t.op.arith.op_class)
      exec_pkg::class_arith: begin
        if (t.op.arith.func == exec_pkg::func_sub) begin
          r.data = t.a - t.b;
          f.c = t.a < t.b;  // borrow
          f.o = (t.a[63] != t.b[63]) && (r.data[63] != t.a[63]);
        end else begin
          wide = {1'b0, t.a} + {1'b0, t.b};
          r.data = wide[63:0];
          f.c = wide[64];
          f.o = (t.a[63] == t.b[63]) && (r.data[63] != t.a[63]);
        end
      end
      exec_pkg::class_logic: begin
        case (t.op.arith.func)
          exec_pkg::func_and: r.data = t.a & t.b;
          exec_pkg::func_or:  r.data = t.a | t.b;
          default:            r.data = t.a ^ t.b;
        endcase
      end
      default: begin
        if (t.op.shift.dir == exec_pkg::dir_left) r.data = t.a << amt;
        else if (t.op.shift.arith) r.data = $signed(t.a) >>> amt;
        else r.data = t.a >> amt;
      end
    endcase
    f.z = r.data == 64'd0;
    f.s = r.data[63];
    holds = cond_holds(t.op.arith.cond, t.flags_in);
    r.valid = 1'b1;
    r.wr_en = holds;
    r.flags = holds ? f : t.flags_in;
    return r;
  endfunction

  task automatic check_result(input exec_pkg::result_t exp, input exec_pkg::result_t got);
    if (got.data !== exp.data) begin
      $display("MISMATCH at %0t: data %h, expected %h", $time, got.data, exp.data);
      errors++;
    end
    if (got.wr_en !== exp.wr_en) begin
      $display("MISMATCH at %0t: wr_en %b, expected %b", $time, got.wr_en, exp.wr_en);
      errors++;
    end
  endtask

  task automatic check_flags(input cond_pkg::flags_t exp, input cond_pkg::flags_t got);
    if (got !== exp) begin
      $display("MISMATCH at %0t: flags zsco %b, expected %b", $time, got, exp);
      errors++;
    end
  endtask

  task automatic send(input exec_pkg::issue_t t);
    @(posedge clk);
    issue <= t;
    if (t.valid) begin
      expect_q.push_back(expected_result(t));
      n_issued++;
    end
  endtask

  task automatic finish_test(input string name);
    send('0);
    for (int w = 0; w < exec_pkg::LATENCY + 2 && expect_q.size() != 0; w++) begin
      @(posedge clk);
    end
    @(negedge clk);
    $display("test %-12s %4d ops, %0d errors", name, n_issued - ops_mark, errors - err_mark);
    ops_mark = n_issued;
    err_mark = errors;
  endtask

  // compare at the falling edge, results settle after the rising one
  always @(negedge clk) begin
    if (!rst) begin
      if (result.valid !== valid_d2) begin
        $display("MISMATCH at %0t: result.valid %b, expected %b", $time, result.valid,
                 valid_d2);
        errors++;
      end
      if (result.valid === 1'b1) begin
        if (expect_q.size() == 0) begin
          $display("result strobe at %0t with no operation outstanding", $time);
          errors++;
        end else begin
          exp_r = expect_q.pop_front();
          check_result(exp_r, result);
          check_flags(exp_r.flags, result.flags);
          n_checked++;
        end
      end
    end
    valid_d2 = valid_d1;
    valid_d1 = issue.valid;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles with %0d results still outstanding", cycles,
             expect_q.size());
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : stimulus
    exec_pkg::issue_t t;
    logic [63:0]      a;
    logic [63:0]      b;
    issue = '0;
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    // carries across bit 31 and bit 63, signed overflow, borrow
    send(arith_op(exec_pkg::class_arith, exec_pkg::func_add, cond_pkg::cond_al,
                  64'h0000_0000_ffff_ffff, 64'd1, '0));
    send(arith_op(exec_pkg::class_arith, exec_pkg::func_add, cond_pkg::cond_al,
                  64'hffff_ffff_ffff_ffff, 64'd1, '0));
    send(arith_op(exec_pkg::class_arith, exec_pkg::func_add, cond_pkg::cond_al,
                  64'h7fff_ffff_ffff_ffff, 64'd1, '0));
    send(arith_op(exec_pkg::class_arith, exec_pkg::func_add, cond_pkg::cond_al,
                  64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, '0));
    send(arith_op(exec_pkg::class_arith, exec_pkg::func_sub, cond_pkg::cond_al,
                  64'h0000_0001_0000_0000, 64'd1, '0));
    send(arith_op(exec_pkg::class_arith, exec_pkg::func_sub, cond_pkg::cond_al,
                  64'd0, 64'd1, '0));
    send(arith_op(exec_pkg::class_arith, exec_pkg::func_sub, cond_pkg::cond_al,
                  64'h8000_0000_0000_0000, 64'd1, '0));
    send(arith_op(exec_pkg::class_arith, exec_pkg::func_sub, cond_pkg::cond_al,
                  64'd5, 64'd5, '0));
    for (int k = 0; k < 8; k++) begin
      a = rand64();
      b = rand64();
      send(arith_op(exec_pkg::class_arith, k[0] ? exec_pkg::func_sub : exec_pkg::func_add,
                    cond_pkg::cond_al, a, b, '0));
    end
    finish_test("add_sub");

    for (int k = 0; k < 8; k++) begin
      a = rand64();
      b = rand64();
      send(arith_op(exec_pkg::class_logic, exec_pkg::func_and, cond_pkg::cond_al, a, b, '0));
      send(arith_op(exec_pkg::class_logic, exec_pkg::func_or, cond_pkg::cond_al, a, b, '0));
      send(arith_op(exec_pkg::class_logic, exec_pkg::func_xor, cond_pkg::cond_al, a, b, '0));
    end
    send(arith_op(exec_pkg::class_logic, exec_pkg::func_xor, cond_pkg::cond_al, a, a, '0));
    send(arith_op(exec_pkg::class_logic, exec_pkg::func_and, cond_pkg::cond_al, a, ~a, '0));
    finish_test("logic");

    // left, right, arith right, each from b and from the immediate
    for (int m = 0; m < 6; m++) begin
      for (int k = 0; k < 8; k++) begin
        a = rand64();
        b = rand64();
        send(shift_op(exec_pkg::shift_dir_e'(m >= 2), m >= 4, m % 2 == 1, b[37:32],
                      cond_pkg::cond_al, a, b, '0));
      end
    end
    finish_test("shift");

    for (int c = 0; c < 16; c++) begin
      for (int k = 0; k < 4; k++) begin
        t = random_op();
        t.op.arith.cond = cond_pkg::cond_e'(c);  // same bits in the shift form
        send(t);
      end
    end
    finish_test("cond_codes");

    for (int k = 0; k < 200; k++) send(random_op());
    finish_test("back2back");

    for (int k = 0; k < GAP_SLOTS; k++) begin
      t = random_op();
      t.valid = ^next_rand();
      send(t);
    end
    finish_test("gaps");

    if (expect_q.size() != 0) begin
      $display("%0d expected results never arrived", expect_q.size());
      errors++;
    end
    errors += UUT.u_checker.assert_errs;
    $display("issued %0d, checked %0d, errors %0d, assertion failures %0d", n_issued,
             n_checked, errors, UUT.u_checker.assert_errs);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- exec_slice.f
hdl/cond_pkg.sv
hdl/exec_pkg.sv
hdl/int_alu.sv
hdl/cond_eval.sv
hdl/result_merge.sv
hdl/exec_slice.sv
verification/exec_slice_checker.sv
verification/exec_slice_tb.sv
